//--- Bender.yml
package:
  name: vs_filter_axi

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vsf_reg_pkg.sv
      - rtl/vsf_chan_pkg.sv
      - rtl/vsf_axil_slave.sv
      - rtl/vsf_regbank.sv
      - rtl/vsf_vs_filter.sv
      - rtl/vsf_rate_meter.sv
      - rtl/vs_filter_axi.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/vsf_tb.sv

//--- dv/vsf_tb.sv
`timescale 1ns/100ps
`include "vsf_defines.svh"

module vsf_tb;

    localparam int NCH = `VSF_NUM_CH;

    logic                  S_AXI_ACLK;
    logic                  S_AXI_ARESETN;
    logic [15:0]           awaddr, araddr;
    logic                  awvalid, wvalid, bready, arvalid, rready;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic                  awready, wready, bvalid, arready, rvalid;
    logic [1:0]            bresp, rresp;
    logic [31:0]           rdata;
    logic [NCH-1:0]        vs_in, vs_out, vs_stable, vs_timeout;

    logic [31:0] lfsr;
    int          mismatches, failures;
    bit          chk, run;
    bit          hold [NCH];
    int          phase [NCH], period [NCH];

    // reference model state
    bit m_s0 [NCH], m_s1 [NCH], m_sd [NCH], m_out [NCH], m_out_d [NCH];
    bit m_tmo [NCH], m_stable [NCH], m_en [NCH];
    bit m_out_en [NCH];                             // enable that gated m_out
    bit hist [NCH][3];                              // vs_in as sampled, last 3 edges
    int m_cnt [NCH], m_prev [NCH], m_stab [NCH], m_times [NCH], m_thresh [NCH];
    int win, raw_c [NCH], filt_c [NCH], raw_l [NCH], filt_l [NCH];

    vs_filter_axi dut0 (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .s_axi_awaddr (awaddr), .s_axi_awvalid (awvalid), .s_axi_awready (awready),
        .s_axi_wdata (wdata), .s_axi_wstrb (wstrb), .s_axi_wvalid (wvalid),
        .s_axi_wready (wready), .s_axi_bresp (bresp), .s_axi_bvalid (bvalid),
        .s_axi_bready (bready), .s_axi_araddr (araddr), .s_axi_arvalid (arvalid),
        .s_axi_arready (arready), .s_axi_rdata (rdata), .s_axi_rresp (rresp),
        .s_axi_rvalid (rvalid), .s_axi_rready (rready),
        .vs_in, .vs_out, .vs_stable, .vs_timeout
    );

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #50 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int new_period(int ch);
        if (take_bits(2) == 0)
            return 40 + int'(take_bits(8));                    // erratic
        return 150 + 50 * ch + int'(take_bits(5)) - 16;         // jitter around base
    endfunction

    task automatic expect_eq(string what, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic cycles(int n);
        repeat (n) @(posedge S_AXI_ACLK);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus tasks
    task automatic write_reg(logic [15:0] a, logic [31:0] d);
        int t;
        awaddr  = a;
        wdata   = d;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        t = 0;
        while (!awready && t < 20) begin
            cycles(1);
            t++;
        end
        assert (awready && wready) else begin
            failures++;
            $display("write address and data were not accepted together");
        end
        cycles(1);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        t = 0;
        while (!bvalid && t < 20) begin
            cycles(1);
            t++;
        end
        assert (bvalid) else begin
            failures++;
            $display("write response never came");
        end
        expect_eq("bresp", bresp, 2'b00);
        cycles(1);                                      // register now live in the filters
        for (int n = 0; n < NCH; n++) begin
            if (a == `VSF_ADDR_FILTER_EN)
                m_en[n] = d[n];
            if (a == `VSF_ADDR_TIMES_BASE + 4 * n)
                m_times[n] = d[7:0];
            if (a == `VSF_ADDR_THRESH_BASE + 4 * n)
                m_thresh[n] = d[15:0];
        end
    endtask

    task automatic read_reg(logic [15:0] a, output logic [31:0] d);
        int t;
        araddr  = a;
        arvalid = 1'b1;
        t = 0;
        while (!arready && t < 20) begin
            cycles(1);
            t++;
        end
        assert (arready) else begin
            failures++;
            $display("read address was never accepted");
        end
        cycles(1);
        arvalid = 1'b0;
        t = 0;
        while (!rvalid && t < 20) begin
            cycles(1);
            t++;
        end
        assert (rvalid) else begin
            failures++;
            $display("read data never came");
        end
        d = rdata;
        expect_eq("rresp", rresp, 2'b00);
        cycles(1);
    endtask

    task automatic check_reg(logic [15:0] a, logic [31:0] exp);
        logic [31:0] d;
        read_reg(a, d);
        expect_eq($sformatf("reg %h", a), d, exp);
    endtask

    function automatic logic [31:0] stable_word();
        logic [31:0] w;
        w = '0;
        for (int n = 0; n < NCH; n++)
            w[n] = m_stable[n];
        return w;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus and reference model
    always @(posedge S_AXI_ACLK) begin
        #2;
        for (int n = 0; n < NCH; n++) begin
            if (run) begin
                phase[n]++;
                if (phase[n] >= period[n]) begin
                    phase[n]  = 0;
                    period[n] = new_period(n);
                end
            end
            vs_in[n] = run && !hold[n] && phase[n] < 4;   // 4-cycle high pulse
        end
    end

    always @(posedge S_AXI_ACLK) begin
        bit sync, rise, tmo_n, fedge, wend;
        int stab_n, d;
        wend = (win == `VSF_WINDOW_CYCLES - 1);
        win  = (!S_AXI_ARESETN || wend) ? 0 : win + 1;
        for (int n = 0; n < NCH; n++) begin
            if (!S_AXI_ARESETN) begin
                m_s0[n]     = 0;
                m_s1[n]     = 0;
                m_sd[n]     = 0;
                m_out[n]    = 0;
                m_out_d[n]  = 0;
                m_out_en[n] = 1;
                m_tmo[n]    = 0;
                m_stable[n] = 0;
                m_cnt[n]    = 0;
                m_prev[n]   = 0;
                m_stab[n]   = 0;
                m_en[n]     = 1;
                m_times[n]  = 3;
                m_thresh[n] = 16;
                raw_c[n]    = 0;
                filt_c[n]   = 0;
                raw_l[n]    = 0;
                filt_l[n]   = 0;
            end else begin
                sync   = m_s1[n];
                rise   = sync && !m_sd[n];
                fedge  = m_out[n] && !m_out_d[n];
                stab_n = m_stab[n];
                tmo_n  = m_tmo[n];
                if (rise) begin
                    tmo_n = 0;
                    d = (m_cnt[n] > m_prev[n]) ? m_cnt[n] - m_prev[n] : m_prev[n] - m_cnt[n];
                    if (d <= m_thresh[n])
                        stab_n = (m_stab[n] + 1 > m_times[n]) ? m_times[n] : m_stab[n] + 1;
                    else
                        stab_n = 0;
                end else if (m_cnt[n] == `VSF_TIMEOUT_CYCLES - 1) begin
                    tmo_n  = 1;
                    stab_n = 0;
                end
                m_stab[n]   = stab_n;
                m_tmo[n]    = tmo_n;
                m_stable[n] = (stab_n >= m_times[n]) && !tmo_n;
                m_out_d[n]  = m_out[n];
                m_out_en[n] = m_en[n];
                m_out[n]    = sync && (!m_en[n] || m_stable[n]);
                if (rise) begin
                    m_prev[n] = m_cnt[n];
                    m_cnt[n]  = 0;
                end else begin
                    m_cnt[n]++;
                end
                raw_c[n]  = (rise && raw_c[n] < 255) ? raw_c[n] + 1 : raw_c[n];
                filt_c[n] = (fedge && filt_c[n] < 255) ? filt_c[n] + 1 : filt_c[n];
                if (wend) begin
                    raw_l[n]  = raw_c[n];
                    filt_l[n] = filt_c[n];
                    raw_c[n]  = 0;
                    filt_c[n] = 0;
                end
                m_sd[n] = sync;
                m_s1[n] = m_s0[n];
            end
            m_s0[n]    = S_AXI_ARESETN && vs_in[n];
            hist[n][2] = hist[n][1];
            hist[n][1] = hist[n][0];
            hist[n][0] = vs_in[n];
        end
    end

    always @(negedge S_AXI_ACLK) begin
        if (chk) begin
            for (int n = 0; n < NCH; n++) begin
                expect_eq($sformatf("vs_out[%0d]", n), vs_out[n], m_out[n]);
                expect_eq($sformatf("vs_stable[%0d]", n), vs_stable[n], m_stable[n]);
                expect_eq($sformatf("vs_timeout[%0d]", n), vs_timeout[n], m_tmo[n]);
                if (!m_out_en[n])
                    expect_eq($sformatf("bypass vs_out[%0d]", n), vs_out[n], hist[n][2]);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    initial begin
        logic [31:0] d, v;
        vsf_reg_pkg::rate_word_u rw, fw;
        int t;
        lfsr       = 32'h13a1_30a3;
        mismatches = 0;
        failures   = 0;
        chk        = 0;
        run        = 0;
        win        = 0;
        awaddr     = '0;
        wdata      = '0;
        wstrb      = 4'hf;
        awvalid    = 0;
        wvalid     = 0;
        bready     = 1;
        araddr     = '0;
        arvalid    = 0;
        rready     = 1;
        vs_in      = '0;
        for (int n = 0; n < NCH; n++) begin
            hold[n]   = 0;
            phase[n]  = 0;
            period[n] = new_period(n);
        end
        S_AXI_ARESETN = 1'b0;
        cycles(16);
        S_AXI_ARESETN = 1'b1;
        chk = 1;

        check_reg(`VSF_ADDR_FILTER_EN, 32'hf);   // reset defaults
        for (int n = 0; n < NCH; n++) begin
            check_reg(`VSF_ADDR_TIMES_BASE + 4 * n, 3);
            check_reg(`VSF_ADDR_THRESH_BASE + 4 * n, 16);
        end
        check_reg(16'h0014, 0);
        check_reg(16'h1010, 0);
        check_reg(16'h3000, 0);

        for (int n = 0; n < NCH; n++) begin       // random readback
            v = take_bits(32);
            write_reg(`VSF_ADDR_TIMES_BASE + 4 * n, v);
            check_reg(`VSF_ADDR_TIMES_BASE + 4 * n, v[7:0]);
            v = take_bits(32);
            write_reg(`VSF_ADDR_THRESH_BASE + 4 * n, v);
            check_reg(`VSF_ADDR_THRESH_BASE + 4 * n, v[15:0]);
        end
        v = take_bits(32);
        write_reg(`VSF_ADDR_FILTER_EN, v);
        check_reg(`VSF_ADDR_FILTER_EN, v[3:0]);

        for (int n = 0; n < NCH; n++) begin       // working configuration
            write_reg(`VSF_ADDR_TIMES_BASE + 4 * n, 1 + take_bits(2));
            write_reg(`VSF_ADDR_THRESH_BASE + 4 * n, 8 + take_bits(5));
        end
        write_reg(`VSF_ADDR_FILTER_EN, 32'hf);

        run = 1;
        repeat (10) begin                         // stable status while VS idles
            cycles(600);
            run = 0;
            cycles(3);                            // edges still in the synchronizer land
            check_reg(`VSF_ADDR_STABLE, stable_word());
            run = 1;
        end

        write_reg(`VSF_ADDR_FILTER_EN, 32'ha);    // ch0 and ch2 bypassed
        cycles(3000);
        write_reg(`VSF_ADDR_FILTER_EN, 32'hf);

        hold[1] = 1;                              // no edges on ch1
        t = 0;
        while (!m_tmo[1] && t < 3000) begin
            cycles(1);
            t++;
        end
        assert (m_tmo[1]) else begin
            failures++;
            $display("channel 1 never timed out");
        end
        run = 0;
        read_reg(`VSF_ADDR_TIMEOUT, d);
        expect_eq("timeout status ch1", d[1], 1'b1);
        expect_eq("stable ch1 in timeout", vs_stable[1], 1'b0);
        run = 1;
        hold[1] = 0;
        t = 0;
        while (m_tmo[1] && t < 1000) begin
            cycles(1);
            t++;
        end
        assert (!m_tmo[1]) else begin
            failures++;
            $display("channel 1 timeout never cleared");
        end

        repeat (3) begin                          // rates over whole windows
            cycles(2 * `VSF_WINDOW_CYCLES);
            t = 0;
            while (win != 20 && t < `VSF_WINDOW_CYCLES + 10) begin
                cycles(1);
                t++;
            end
            assert (win == 20) else begin
                failures++;
                $display("rate window position was never reached");
            end
            read_reg(`VSF_ADDR_RATE_RAW, rw.word);
            read_reg(`VSF_ADDR_RATE_FILT, fw.word);
            for (int n = 0; n < NCH; n++) begin
                expect_eq($sformatf("raw rate ch%0d", n), rw.rate[n], raw_l[n]);
                expect_eq($sformatf("filt rate ch%0d", n), fw.rate[n], filt_l[n]);
            end
        end

        chk = 0;
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- rtl/vs_filter_axi.sv
`timescale 1ns/100ps
`include "vsf_defines.svh"

module vs_filter_axi (
    input  logic                     S_AXI_ACLK,
    input  logic                     S_AXI_ARESETN,
    input  vsf_reg_pkg::addr_t       s_axi_awaddr,
    input  logic                     s_axi_awvalid,
    output logic                     s_axi_awready,
    input  vsf_reg_pkg::data_t       s_axi_wdata,
    input  logic [`VSF_DATA_W/8-1:0] s_axi_wstrb,
    input  logic                     s_axi_wvalid,
    output logic                     s_axi_wready,
    output logic [1:0]               s_axi_bresp,
    output logic                     s_axi_bvalid,
    input  logic                     s_axi_bready,
    input  vsf_reg_pkg::addr_t       s_axi_araddr,
    input  logic                     s_axi_arvalid,
    output logic                     s_axi_arready,
    output vsf_reg_pkg::data_t       s_axi_rdata,
    output logic [1:0]               s_axi_rresp,
    output logic                     s_axi_rvalid,
    input  logic                     s_axi_rready,
    input  logic [`VSF_NUM_CH-1:0]   vs_in,
    output logic [`VSF_NUM_CH-1:0]   vs_out,
    output logic [`VSF_NUM_CH-1:0]   vs_stable,
    output logic [`VSF_NUM_CH-1:0]   vs_timeout
);

    logic                                   wr_req;
    vsf_reg_pkg::addr_t                     wr_addr;
    vsf_reg_pkg::data_t                     wr_data;
    logic                                   rd_req;
    vsf_reg_pkg::addr_t                     rd_addr;
    logic                                   rd_done;
    vsf_reg_pkg::data_t                     rd_data;
    logic [`VSF_NUM_CH-1:0]                 filter_en;
    vsf_chan_pkg::times_t [`VSF_NUM_CH-1:0] times;
    vsf_chan_pkg::thresh_t [`VSF_NUM_CH-1:0] thresh;
    logic [`VSF_NUM_CH-1:0]                 vs_sync;    // raw VS after synchronizer
    vsf_chan_pkg::rate_t [`VSF_NUM_CH-1:0]  rate_raw;
    vsf_chan_pkg::rate_t [`VSF_NUM_CH-1:0]  rate_filt;

    vsf_axil_slave u_slave (.*);

    vsf_regbank u_regbank (.*);

    //////////////////////////////////////////////////////////////////////
    // one filter per VS channel
    for (genvar i = 0; i < `VSF_NUM_CH; i++) begin : g_ch
        vsf_vs_filter u_filter (
            .S_AXI_ACLK    (S_AXI_ACLK),
            .S_AXI_ARESETN (S_AXI_ARESETN),
            .vs_in         (vs_in[i]),
            .filter_en     (filter_en[i]),
            .times         (times[i]),
            .thresh        (thresh[i]),
            .vs_sync       (vs_sync[i]),
            .vs_out        (vs_out[i]),
            .stable        (vs_stable[i]),
            .timeout       (vs_timeout[i])
        );
    end

    vsf_rate_meter u_meter (
        .vs_filt (vs_out),   // filtered edges come from the gated output
        .*
    );

endmodule

//--- rtl/vsf_axil_slave.sv
`timescale 1ns/100ps
`include "vsf_defines.svh"

module vsf_axil_slave (
    input  logic                     S_AXI_ACLK,
    input  logic                     S_AXI_ARESETN,
    input  vsf_reg_pkg::addr_t       s_axi_awaddr,
    input  logic                     s_axi_awvalid,
    output logic                     s_axi_awready,
    input  vsf_reg_pkg::data_t       s_axi_wdata,
    input  logic [`VSF_DATA_W/8-1:0] s_axi_wstrb,
    input  logic                     s_axi_wvalid,
    output logic                     s_axi_wready,
    output logic [1:0]               s_axi_bresp,
    output logic                     s_axi_bvalid,
    input  logic                     s_axi_bready,
    input  vsf_reg_pkg::addr_t       s_axi_araddr,
    input  logic                     s_axi_arvalid,
    output logic                     s_axi_arready,
    output vsf_reg_pkg::data_t       s_axi_rdata,
    output logic [1:0]               s_axi_rresp,
    output logic                     s_axi_rvalid,
    input  logic                     s_axi_rready,
    output logic                     wr_req,
    output vsf_reg_pkg::addr_t       wr_addr,
    output vsf_reg_pkg::data_t       wr_data,
    output logic                     rd_req,
    output vsf_reg_pkg::addr_t       rd_addr,
    input  logic                     rd_done,
    input  vsf_reg_pkg::data_t       rd_data
);

    logic wr_go;    // address and data both offered, no response pending
    logic aw_hs;
    logic ar_hs;
    logic rd_pend;  // read in flight until rdata is taken

    assign wr_go = s_axi_awvalid & s_axi_wvalid & ~s_axi_awready & ~s_axi_bvalid;
    assign aw_hs = s_axi_awready & s_axi_awvalid & s_axi_wvalid;
    assign ar_hs = s_axi_arready & s_axi_arvalid;

    assign s_axi_bresp = vsf_reg_pkg::OKAY;
    assign s_axi_rresp = vsf_reg_pkg::OKAY;

    //////////////////////////////////////////////////////////////////////
    // write channel
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            wr_req        <= 1'b0;
        end else begin
            s_axi_awready <= wr_go;   // one-cycle ready pulse
            s_axi_wready  <= wr_go;
            wr_req        <= aw_hs;
            if (aw_hs)
                s_axi_bvalid <= 1'b1;
            else if (s_axi_bready)
                s_axi_bvalid <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read channel
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            rd_req        <= 1'b0;
            rd_pend       <= 1'b0;
        end else begin
            s_axi_arready <= s_axi_arvalid & ~s_axi_arready & ~rd_pend;
            rd_req        <= ar_hs;
            if (ar_hs)
                rd_pend <= 1'b1;
            else if (s_axi_rvalid && s_axi_rready)
                rd_pend <= 1'b0;
            if (rd_done)
                s_axi_rvalid <= 1'b1;  // bank answers one cycle after rd_req
            else if (s_axi_rready)
                s_axi_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs) begin
            wr_addr <= s_axi_awaddr;
            wr_data <= s_axi_wdata;
        end
        if (ar_hs)
            rd_addr <= s_axi_araddr;
        if (rd_done)
            s_axi_rdata <= rd_data;
    end

    a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

    a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

    // register map only takes full words
    a_full_word: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        aw_hs |-> &s_axi_wstrb);

endmodule

//--- rtl/vsf_chan_pkg.sv
`include "vsf_defines.svh"

package vsf_chan_pkg;

    typedef logic [`VSF_TIMES_W-1:0]    times_t;     // required stable intervals
    typedef logic [`VSF_THRESH_W-1:0]   thresh_t;    // interval tolerance in clocks
    typedef logic [`VSF_INTERVAL_W-1:0] interval_t;
    typedef logic [`VSF_RATE_W-1:0]     rate_t;      // edges per window

endpackage

//--- rtl/vsf_defines.svh
`ifndef VSF_DEFINES_SVH
`define VSF_DEFINES_SVH

// channel and bus geometry
`define VSF_NUM_CH          4
`define VSF_ADDR_W          16
`define VSF_DATA_W          32
`define VSF_TIMES_W         8
`define VSF_THRESH_W        16
`define VSF_INTERVAL_W      24
`define VSF_RATE_W          8
`define VSF_SYNC_STAGES     2

`define VSF_WINDOW_CYCLES   4000  // rate window in clocks
`define VSF_TIMEOUT_CYCLES  1500  // no edge for this long means timeout

`define VSF_EN_DEFAULT      {`VSF_NUM_CH{1'b1}}
`define VSF_TIMES_DEFAULT   3
`define VSF_THRESH_DEFAULT  16

`define VSF_ADDR_FILTER_EN   16'h0000
`define VSF_ADDR_STABLE      16'h0004
`define VSF_ADDR_TIMEOUT     16'h0008
`define VSF_ADDR_RATE_RAW    16'h000C
`define VSF_ADDR_RATE_FILT   16'h0010
`define VSF_ADDR_TIMES_BASE  16'h1000  // channel n at base + 4n
`define VSF_ADDR_THRESH_BASE 16'h2000  // channel n at base + 4n

`endif

//--- rtl/vsf_rate_meter.sv
`timescale 1ns/100ps
`include "vsf_defines.svh"

module vsf_rate_meter (
    input  logic                                  S_AXI_ACLK,
    input  logic                                  S_AXI_ARESETN,
    input  logic [`VSF_NUM_CH-1:0]                vs_sync,
    input  logic [`VSF_NUM_CH-1:0]                vs_filt,
    output vsf_chan_pkg::rate_t [`VSF_NUM_CH-1:0] rate_raw,
    output vsf_chan_pkg::rate_t [`VSF_NUM_CH-1:0] rate_filt
);

    localparam int WIN_W = $clog2(`VSF_WINDOW_CYCLES);

    logic [WIN_W-1:0]                      win_cnt;
    logic                                  win_end;
    logic [`VSF_NUM_CH-1:0]                sync_d;
    logic [`VSF_NUM_CH-1:0]                filt_d;
    vsf_chan_pkg::rate_t [`VSF_NUM_CH-1:0] raw_cnt;
    vsf_chan_pkg::rate_t [`VSF_NUM_CH-1:0] filt_cnt;
    vsf_chan_pkg::rate_t [`VSF_NUM_CH-1:0] raw_nxt;
    vsf_chan_pkg::rate_t [`VSF_NUM_CH-1:0] filt_nxt;

    function automatic vsf_chan_pkg::rate_t sat_add(vsf_chan_pkg::rate_t c, logic e);
        return (e && ~&c) ? c + 1'b1 : c;   // stick at 255
    endfunction

    assign win_end = (win_cnt == WIN_W'(`VSF_WINDOW_CYCLES - 1));

    always_comb begin
        for (int n = 0; n < `VSF_NUM_CH; n++) begin
            raw_nxt[n]  = sat_add(raw_cnt[n], vs_sync[n] & ~sync_d[n]);
            filt_nxt[n] = sat_add(filt_cnt[n], vs_filt[n] & ~filt_d[n]);
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            win_cnt   <= '0;
            sync_d    <= '0;
            filt_d    <= '0;
            raw_cnt   <= '0;
            filt_cnt  <= '0;
            rate_raw  <= '0;
            rate_filt <= '0;
        end else begin
            win_cnt <= win_end ? '0 : win_cnt + 1'b1;
            sync_d  <= vs_sync;
            filt_d  <= vs_filt;
            if (win_end) begin
                rate_raw  <= raw_nxt;    // latch, hold for the next window
                rate_filt <= filt_nxt;
                raw_cnt   <= '0;
                filt_cnt  <= '0;
            end else begin
                raw_cnt  <= raw_nxt;
                filt_cnt <= filt_nxt;
            end
        end
    end

    a_rate_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        !win_end |=> $stable(rate_raw) && $stable(rate_filt));

endmodule

//--- rtl/vsf_reg_pkg.sv
`include "vsf_defines.svh"

package vsf_reg_pkg;

    typedef logic [`VSF_ADDR_W-1:0] addr_t;
    typedef logic [`VSF_DATA_W-1:0] data_t;

    // bus word or per-channel rate bytes, ch0 in the low byte
    typedef union packed {
        data_t                                   word;
        logic [`VSF_NUM_CH-1:0][`VSF_RATE_W-1:0] rate;
    } rate_word_u;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

endpackage

//--- rtl/vsf_regbank.sv
`timescale 1ns/100ps
`include "vsf_defines.svh"

module vsf_regbank (
    input  logic                                   S_AXI_ACLK,
    input  logic                                   S_AXI_ARESETN,
    input  logic                                   wr_req,
    input  vsf_reg_pkg::addr_t                     wr_addr,
    input  vsf_reg_pkg::data_t                     wr_data,
    input  logic                                   rd_req,
    input  vsf_reg_pkg::addr_t                     rd_addr,
    input  logic [`VSF_NUM_CH-1:0]                 vs_stable,
    input  logic [`VSF_NUM_CH-1:0]                 vs_timeout,
    input  vsf_chan_pkg::rate_t [`VSF_NUM_CH-1:0]  rate_raw,
    input  vsf_chan_pkg::rate_t [`VSF_NUM_CH-1:0]  rate_filt,
    output logic                                   rd_done,
    output vsf_reg_pkg::data_t                     rd_data,
    output logic [`VSF_NUM_CH-1:0]                 filter_en,
    output vsf_chan_pkg::times_t [`VSF_NUM_CH-1:0] times,
    output vsf_chan_pkg::thresh_t [`VSF_NUM_CH-1:0] thresh
);

    vsf_reg_pkg::rate_word_u raw_word;
    vsf_reg_pkg::rate_word_u filt_word;
    vsf_reg_pkg::data_t      rd_mux;

    function automatic vsf_reg_pkg::addr_t chan_addr(vsf_reg_pkg::addr_t base, int n);
        return base + vsf_reg_pkg::addr_t'(4 * n);
    endfunction

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            filter_en <= `VSF_EN_DEFAULT;
            for (int n = 0; n < `VSF_NUM_CH; n++) begin
                times[n]  <= vsf_chan_pkg::times_t'(`VSF_TIMES_DEFAULT);
                thresh[n] <= vsf_chan_pkg::thresh_t'(`VSF_THRESH_DEFAULT);
            end
        end else if (wr_req) begin
            if (wr_addr == `VSF_ADDR_FILTER_EN)
                filter_en <= wr_data[`VSF_NUM_CH-1:0];
            for (int n = 0; n < `VSF_NUM_CH; n++) begin
                if (wr_addr == chan_addr(`VSF_ADDR_TIMES_BASE, n))
                    times[n] <= wr_data[`VSF_TIMES_W-1:0];
                if (wr_addr == chan_addr(`VSF_ADDR_THRESH_BASE, n))
                    thresh[n] <= wr_data[`VSF_THRESH_W-1:0];
            end
        end
    end

    always_comb begin
        for (int n = 0; n < `VSF_NUM_CH; n++) begin
            raw_word.rate[n]  = rate_raw[n];
            filt_word.rate[n] = rate_filt[n];
        end
    end

    always_comb begin
        rd_mux = '0;   // unmapped reads give zero
        case (rd_addr)
            `VSF_ADDR_FILTER_EN: rd_mux[`VSF_NUM_CH-1:0] = filter_en;
            `VSF_ADDR_STABLE:    rd_mux[`VSF_NUM_CH-1:0] = vs_stable;
            `VSF_ADDR_TIMEOUT:   rd_mux[`VSF_NUM_CH-1:0] = vs_timeout;
            `VSF_ADDR_RATE_RAW:  rd_mux = raw_word.word;
            `VSF_ADDR_RATE_FILT: rd_mux = filt_word.word;
            default: ;
        endcase
        for (int n = 0; n < `VSF_NUM_CH; n++) begin
            if (rd_addr == chan_addr(`VSF_ADDR_TIMES_BASE, n))
                rd_mux[`VSF_TIMES_W-1:0] = times[n];
            if (rd_addr == chan_addr(`VSF_ADDR_THRESH_BASE, n))
                rd_mux[`VSF_THRESH_W-1:0] = thresh[n];
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN)
            rd_done <= 1'b0;
        else
            rd_done <= rd_req;   // fixed one-cycle read latency
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (rd_req)
            rd_data <= rd_mux;
    end

endmodule

//--- rtl/vsf_vs_filter.sv
`timescale 1ns/100ps
`include "vsf_defines.svh"

module vsf_vs_filter (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,
    input  logic                  vs_in,
    input  logic                  filter_en,
    input  vsf_chan_pkg::times_t  times,
    input  vsf_chan_pkg::thresh_t thresh,
    output logic                  vs_sync,
    output logic                  vs_out,
    output logic                  stable,
    output logic                  timeout
);

    logic [`VSF_SYNC_STAGES-1:0] sync_q;
    logic                        sync_d;      // previous vs_sync
    logic                        rise;
    vsf_chan_pkg::interval_t     cnt;         // clocks since last rising edge
    vsf_chan_pkg::interval_t     prev_int;    // last measured interval
    vsf_chan_pkg::interval_t     diff;
    vsf_chan_pkg::times_t        stab_cnt;
    vsf_chan_pkg::times_t        stab_nxt;
    logic                        tmo_hit;
    logic                        timeout_nxt;
    logic                        stable_nxt;

    assign vs_sync = sync_q[`VSF_SYNC_STAGES-1];
    assign rise    = vs_sync & ~sync_d;
    assign diff    = (cnt > prev_int) ? cnt - prev_int : prev_int - cnt;
    assign tmo_hit = (cnt == vsf_chan_pkg::interval_t'(`VSF_TIMEOUT_CYCLES - 1));

    //////////////////////////////////////////////////////////////////////
    // stability rule, evaluated on each synchronized rising edge
    always_comb begin
        stab_nxt    = stab_cnt;
        timeout_nxt = timeout;
        if (rise) begin
            timeout_nxt = 1'b0;
            if (diff <= vsf_chan_pkg::interval_t'(thresh))
                stab_nxt = (stab_cnt >= times) ? times : stab_cnt + 1'b1;
            else
                stab_nxt = '0;   // interval jumped, start over
        end else if (tmo_hit) begin
            timeout_nxt = 1'b1;
            stab_nxt    = '0;
        end
        stable_nxt = (stab_nxt >= times) && !timeout_nxt;
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            sync_q   <= '0;
            sync_d   <= 1'b0;
            cnt      <= '0;
            prev_int <= '0;
            stab_cnt <= '0;
            timeout  <= 1'b0;
            stable   <= 1'b0;
            vs_out   <= 1'b0;
        end else begin
            sync_q   <= {sync_q[`VSF_SYNC_STAGES-2:0], vs_in};
            sync_d   <= vs_sync;
            stab_cnt <= stab_nxt;
            timeout  <= timeout_nxt;
            stable   <= stable_nxt;
            vs_out   <= vs_sync & (~filter_en | stable_nxt);  // gate matches stable
            if (rise) begin
                prev_int <= cnt;
                cnt      <= '0;
            end else if (~&cnt) begin
                cnt <= cnt + 1'b1;   // saturate, timeout fires once
            end
        end
    end

    a_flags_excl: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        timeout |-> !stable && stab_cnt == '0);

endmodule

//--- vs_filter_axi.f
+incdir+rtl
rtl/vsf_reg_pkg.sv
rtl/vsf_chan_pkg.sv
rtl/vsf_axil_slave.sv
rtl/vsf_regbank.sv
rtl/vsf_vs_filter.sv
rtl/vsf_rate_meter.sv
rtl/vs_filter_axi.sv
dv/vsf_tb.sv
